// ==== hw/dcache_pkg.sv ====
package dcache_pkg;

    // --------------------
    // Address and block geometry.
    // --------------------
    localparam int ADDR_WIDTH  = 32;
    localparam int BLOCK_WIDTH = 512;
    localparam int BLOCK_BYTES = BLOCK_WIDTH / 8;
    localparam int OFFSET_W    = $clog2(BLOCK_BYTES);

    // Load and store data width.
    localparam int REG_WIDTH   = 64;

    // --------------------
    // Associativity.
    // --------------------
    localparam int WAY_COUNT   = 4;
    localparam int WAY_W       = $clog2(WAY_COUNT);

    // Store size as log2 of the byte count.
    typedef enum logic [1:0] {
        ST_BYTE   = 2'b00,
        ST_HALF   = 2'b01,
        ST_WORD   = 2'b10,
        ST_DOUBLE = 2'b11
    } store_type_e;

endpackage

// ==== hw/store_unit.sv ====
`timescale 1ns/1ns

module store_unit import dcache_pkg::*; (
    input  logic [ADDR_WIDTH-1:0]  i_addr,
    input  logic [REG_WIDTH-1:0]   i_wdata,
    input  store_type_e            i_store_type,
    output logic [BLOCK_BYTES-1:0] o_byte_en,
    output logic [BLOCK_WIDTH-1:0] o_store_data,
    output logic                   o_store_misaligned
);

    localparam int LANE_BYTES = REG_WIDTH / 8;
    localparam int LANE_W     = $clog2(LANE_BYTES);

    logic [OFFSET_W-1:0]    s_offset;
    logic [LANE_W-1:0]      s_low_mask;
    logic [OFFSET_W-1:0]    s_base;
    logic [LANE_BYTES-1:0]  s_lane_en;
    logic [BLOCK_BYTES-1:0] s_lane_en_wide;
    logic [REG_WIDTH-1:0]   s_lane_data;

    assign s_offset = i_addr[OFFSET_W-1:0];

    // Offset bits that must be zero for this size.
    assign s_low_mask = LANE_W'((1 << i_store_type) - 1);

    assign o_store_misaligned = |(s_offset[LANE_W-1:0] & s_low_mask);

    // --------------------
    // Byte enables.
    // --------------------
    assign s_lane_en      = LANE_BYTES'((1 << (1 << i_store_type)) - 1);
    assign s_lane_en_wide = {{(BLOCK_BYTES - LANE_BYTES){1'b0}}, s_lane_en};

    // Start byte rounded down to the access size.
    assign s_base = {s_offset[OFFSET_W-1:LANE_W], s_offset[LANE_W-1:0] & ~s_low_mask};

    assign o_byte_en = s_lane_en_wide << s_base;

    // --------------------
    // Store data.
    // --------------------
    always_comb begin
        case (i_store_type)
            ST_BYTE: s_lane_data = {8{i_wdata[7:0]}};
            ST_HALF: s_lane_data = {4{i_wdata[15:0]}};
            ST_WORD: s_lane_data = {2{i_wdata[31:0]}};
            default: s_lane_data = i_wdata;
        endcase
    end

    // Same lane copied into every 64-bit slot.
    assign o_store_data = {(BLOCK_WIDTH / REG_WIDTH){s_lane_data}};

endmodule

// ==== hw/tag_array.sv ====
`timescale 1ns/1ns

module tag_array import dcache_pkg::*; #(
    parameter int SET_COUNT = 16
) (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [WAY_W-1:0]      i_victim,
    input  logic                  i_write_en,
    input  logic                  i_block_write_en,
    input  logic                  i_valid_update,
    input  logic                  i_addr_control,
    output logic                  o_hit,
    output logic [WAY_W-1:0]      o_way,
    output logic                  o_dirty,
    output logic [ADDR_WIDTH-1:0] o_line_addr
);

    localparam int INDEX_W = $clog2(SET_COUNT);
    localparam int TAG_W   = ADDR_WIDTH - INDEX_W - OFFSET_W;

    logic [TAG_W-1:0]      tag_mem   [SET_COUNT][WAY_COUNT];
    logic [WAY_COUNT-1:0]  valid_mem [SET_COUNT];
    logic [WAY_COUNT-1:0]  dirty_mem [SET_COUNT];

    logic [INDEX_W-1:0]    s_index;
    logic [TAG_W-1:0]      s_tag;
    logic [WAY_COUNT-1:0]  s_hit_vec;
    logic [ADDR_WIDTH-1:0] s_refill_addr;
    logic [ADDR_WIDTH-1:0] s_wb_addr;

    assign s_index = i_addr[OFFSET_W +: INDEX_W];
    assign s_tag   = i_addr[ADDR_WIDTH-1 -: TAG_W];

    // --------------------
    // Lookup.
    // --------------------
    always_comb begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            s_hit_vec[w] = valid_mem[s_index][w] && (tag_mem[s_index][w] == s_tag);
        end
    end

    assign o_hit = |s_hit_vec;

    // Lowest hitting way or the victim on a miss.
    always_comb begin
        o_way = i_victim;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (s_hit_vec[w]) begin
                o_way = WAY_W'(w);
            end
        end
    end

    assign o_dirty = dirty_mem[s_index][i_victim];

    assign s_refill_addr = {i_addr[ADDR_WIDTH-1:OFFSET_W], {OFFSET_W{1'b0}}};
    assign s_wb_addr     = {tag_mem[s_index][i_victim], s_index, {OFFSET_W{1'b0}}};
    assign o_line_addr   = i_addr_control ? s_refill_addr : s_wb_addr;

    // --------------------
    // Updates.
    // --------------------
    always_ff @(posedge clk) begin
        if (i_block_write_en && !i_write_en) begin
            tag_mem[s_index][i_victim] <= s_tag;
        end
    end

    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            valid_mem <= '{default: '0};
            dirty_mem <= '{default: '0};
        end else begin
            if (i_write_en) begin
                dirty_mem[s_index][o_way] <= 1'b1;
            end else if (i_block_write_en) begin
                dirty_mem[s_index][i_victim] <= 1'b0;
            end
            if (i_valid_update) begin
                valid_mem[s_index][i_victim] <= 1'b1;
            end
        end
    end

endmodule

// ==== hw/lru_tracker.sv ====
`timescale 1ns/1ns

module lru_tracker import dcache_pkg::*; #(
    parameter int SET_COUNT = 16
) (
    input  logic                  clk,
    input  logic                  arstn,
    input  logic [ADDR_WIDTH-1:0] i_addr,
    input  logic [WAY_W-1:0]      i_way,
    input  logic                  i_lru_update,
    output logic [WAY_W-1:0]      o_victim
);

    localparam int INDEX_W = $clog2(SET_COUNT);

    // Age 0 is least recently used, WAY_COUNT-1 most recent.
    logic [WAY_W-1:0]   age_mem [SET_COUNT][WAY_COUNT];

    logic [INDEX_W-1:0] s_index;
    logic [WAY_W-1:0]   s_way_age;

    assign s_index   = i_addr[OFFSET_W +: INDEX_W];
    assign s_way_age = age_mem[s_index][i_way];

    // Lowest way with age 0.
    always_comb begin
        o_victim = '0;
        for (int w = WAY_COUNT - 1; w >= 0; w--) begin
            if (age_mem[s_index][w] == '0) begin
                o_victim = WAY_W'(w);
            end
        end
    end

    // --------------------
    // Age update.
    // --------------------
    always_ff @(posedge clk or negedge arstn) begin
        if (!arstn) begin
            for (int s = 0; s < SET_COUNT; s++) begin
                for (int w = 0; w < WAY_COUNT; w++) begin
                    age_mem[s][w] <= WAY_W'(w);
                end
            end
        end else if (i_lru_update) begin
            for (int w = 0; w < WAY_COUNT; w++) begin
                if (age_mem[s_index][w] > s_way_age) begin
                    age_mem[s_index][w] <= age_mem[s_index][w] - 1'b1;
                end
            end
            age_mem[s_index][i_way] <= WAY_W'(WAY_COUNT - 1);
        end
    end

endmodule

// ==== hw/data_array.sv ====
`timescale 1ns/1ns

module data_array import dcache_pkg::*; #(
    parameter int SET_COUNT = 16
) (
    input  logic                   clk,
    input  logic [ADDR_WIDTH-1:0]  i_addr,
    input  logic [WAY_W-1:0]       i_way,
    input  logic [WAY_W-1:0]       i_victim,
    input  logic [BLOCK_BYTES-1:0] i_byte_en,
    input  logic [BLOCK_WIDTH-1:0] i_store_data,
    input  logic [BLOCK_WIDTH-1:0] i_block,
    input  logic                   i_write_en,
    input  logic                   i_block_write_en,
    output logic [REG_WIDTH-1:0]   o_rdata,
    output logic [BLOCK_WIDTH-1:0] o_block
);

    localparam int INDEX_W    = $clog2(SET_COUNT);
    localparam int WORD_W     = 32;
    localparam int WORD_OFF_W = OFFSET_W - $clog2(WORD_W / 8);

    logic [BLOCK_WIDTH-1:0]        data_mem [SET_COUNT][WAY_COUNT];

    logic [INDEX_W-1:0]            s_index;
    logic [WORD_OFF_W-1:0]         s_word_off;
    logic [BLOCK_WIDTH+WORD_W-1:0] s_block_ext;

    assign s_index    = i_addr[OFFSET_W +: INDEX_W];
    assign s_word_off = i_addr[OFFSET_W-1 -: WORD_OFF_W];

    // --------------------
    // Write port.
    // --------------------
    always_ff @(posedge clk) begin
        if (i_write_en) begin
            for (int b = 0; b < BLOCK_BYTES; b++) begin
                if (i_byte_en[b]) begin
                    data_mem[s_index][i_way][b*8 +: 8] <= i_store_data[b*8 +: 8];
                end
            end
        end else if (i_block_write_en) begin
            data_mem[s_index][i_victim] <= i_block;
        end
    end

    // --------------------
    // Read port.
    // --------------------
    assign o_block = data_mem[s_index][i_way];

    // Extra zero word fills the top half of the last read.
    assign s_block_ext = {{WORD_W{1'b0}}, o_block};

    assign o_rdata = s_block_ext[s_word_off * WORD_W +: REG_WIDTH];

endmodule

// ==== hw/data_cache.sv ====
`timescale 1ns/1ns

module data_cache import dcache_pkg::*; #(
    parameter int SET_COUNT = 16
) (
    input  logic                   clk,
    input  logic                   arstn,
    input  logic [ADDR_WIDTH-1:0]  i_addr,
    input  logic [REG_WIDTH-1:0]   i_wdata,
    input  logic [BLOCK_WIDTH-1:0] i_block,
    input  store_type_e            i_store_type,
    input  logic                   i_write_en,
    input  logic                   i_block_write_en,
    input  logic                   i_valid_update,
    input  logic                   i_lru_update,
    input  logic                   i_addr_control,
    output logic [REG_WIDTH-1:0]   o_rdata,
    output logic [BLOCK_WIDTH-1:0] o_block,
    output logic                   o_hit,
    output logic                   o_dirty,
    output logic [ADDR_WIDTH-1:0]  o_line_addr,
    output logic                   o_store_misaligned
);

    logic [WAY_W-1:0]       s_victim;
    logic [WAY_W-1:0]       s_way;
    logic [BLOCK_BYTES-1:0] s_byte_en;
    logic [BLOCK_WIDTH-1:0] s_store_data;

    store_unit store_unit_i (
        .i_addr             (i_addr),
        .i_wdata            (i_wdata),
        .i_store_type       (i_store_type),
        .o_byte_en          (s_byte_en),
        .o_store_data       (s_store_data),
        .o_store_misaligned (o_store_misaligned)
    );

    tag_array #(.SET_COUNT(SET_COUNT)) tag_array_i (
        .clk              (clk),
        .arstn            (arstn),
        .i_addr           (i_addr),
        .i_victim         (s_victim),
        .i_write_en       (i_write_en),
        .i_block_write_en (i_block_write_en),
        .i_valid_update   (i_valid_update),
        .i_addr_control   (i_addr_control),
        .o_hit            (o_hit),
        .o_way            (s_way),
        .o_dirty          (o_dirty),
        .o_line_addr      (o_line_addr)
    );

    lru_tracker #(.SET_COUNT(SET_COUNT)) lru_tracker_i (
        .clk          (clk),
        .arstn        (arstn),
        .i_addr       (i_addr),
        .i_way        (s_way),
        .i_lru_update (i_lru_update),
        .o_victim     (s_victim)
    );

    data_array #(.SET_COUNT(SET_COUNT)) data_array_i (
        .clk              (clk),
        .i_addr           (i_addr),
        .i_way            (s_way),
        .i_victim         (s_victim),
        .i_byte_en        (s_byte_en),
        .i_store_data     (s_store_data),
        .i_block          (i_block),
        .i_write_en       (i_write_en),
        .i_block_write_en (i_block_write_en),
        .o_rdata          (o_rdata),
        .o_block          (o_block)
    );

endmodule

// ==== include/cache_ref_model.svh ====
`ifndef CACHE_REF_MODEL_SVH
`define CACHE_REF_MODEL_SVH

// --------------------
// Model state.
// --------------------
localparam int REF_SETS    = 16;
localparam int REF_INDEX_W = $clog2(REF_SETS);
localparam int REF_TAG_W   = ADDR_WIDTH - REF_INDEX_W - OFFSET_W;

logic [REF_TAG_W-1:0]   ref_tag   [REF_SETS][WAY_COUNT];
logic                   ref_valid [REF_SETS][WAY_COUNT];
logic                   ref_dirty [REF_SETS][WAY_COUNT];
int                     ref_age   [REF_SETS][WAY_COUNT];
logic [BLOCK_WIDTH-1:0] ref_block [REF_SETS][WAY_COUNT];

function automatic int ref_index(logic [ADDR_WIDTH-1:0] addr);
    return int'(addr[OFFSET_W +: REF_INDEX_W]);
endfunction

function automatic logic [REF_TAG_W-1:0] ref_tag_of(logic [ADDR_WIDTH-1:0] addr);
    return addr[ADDR_WIDTH-1 -: REF_TAG_W];
endfunction

function automatic void ref_reset();
    for (int s = 0; s < REF_SETS; s++) begin
        for (int w = 0; w < WAY_COUNT; w++) begin
            ref_valid[s][w] = 1'b0;
            ref_dirty[s][w] = 1'b0;
            ref_age[s][w]   = w;
        end
    end
endfunction

// Hit way, or -1 on a miss.
function automatic int ref_lookup(logic [ADDR_WIDTH-1:0] addr);
    int s;
    s = ref_index(addr);
    for (int w = 0; w < WAY_COUNT; w++) begin
        if (ref_valid[s][w] && ref_tag[s][w] == ref_tag_of(addr)) begin
            return w;
        end
    end
    return -1;
endfunction

function automatic int ref_victim(int set);
    for (int w = 0; w < WAY_COUNT; w++) begin
        if (ref_age[set][w] == 0) begin
            return w;
        end
    end
    return 0;
endfunction

function automatic void ref_touch(int set, int way);
    int a;
    a = ref_age[set][way];
    for (int w = 0; w < WAY_COUNT; w++) begin
        if (ref_age[set][w] > a) begin
            ref_age[set][w]--;
        end
    end
    ref_age[set][way] = WAY_COUNT - 1;
endfunction

function automatic void ref_refill(logic [ADDR_WIDTH-1:0] addr, logic [BLOCK_WIDTH-1:0] blk);
    int s;
    int v;
    s = ref_index(addr);
    v = ref_victim(s);
    ref_tag[s][v]   = ref_tag_of(addr);
    ref_block[s][v] = blk;
    ref_dirty[s][v] = 1'b0;
    ref_valid[s][v] = 1'b1;
endfunction

// --------------------
// Store and read rules.
// --------------------
function automatic bit ref_misaligned(logic [ADDR_WIDTH-1:0] addr, store_type_e st);
    case (st)
        ST_HALF:   return addr[0];
        ST_WORD:   return |addr[1:0];
        ST_DOUBLE: return |addr[2:0];
        default:   return 1'b0;
    endcase
endfunction

function automatic logic [BLOCK_WIDTH-1:0] ref_merge(logic [BLOCK_WIDTH-1:0] blk,
                                                     logic [ADDR_WIDTH-1:0] addr,
                                                     store_type_e st,
                                                     logic [REG_WIDTH-1:0] wdata);
    int n;
    int base;
    n    = 1 << int'(st);
    base = int'(addr[OFFSET_W-1:0]);
    base = base - (base % n);
    for (int i = 0; i < n; i++) begin
        blk[(base + i) * 8 +: 8] = wdata[i * 8 +: 8];
    end
    return blk;
endfunction

function automatic logic [REG_WIDTH-1:0] ref_read_word(logic [BLOCK_WIDTH-1:0] blk,
                                                       logic [ADDR_WIDTH-1:0] addr);
    logic [REG_WIDTH-1:0] r;
    int pos;
    for (int i = 0; i < REG_WIDTH; i++) begin
        pos  = int'(addr[OFFSET_W-1:2]) * 32 + i;
        r[i] = (pos < BLOCK_WIDTH) ? blk[pos] : 1'b0;
    end
    return r;
endfunction

`endif

// ==== sim/tb_data_cache.sv ====
`timescale 1ns/1ns

module tb_data_cache import dcache_pkg::*; ();

    `include "cache_ref_model.svh"

    localparam int CLK_PERIOD     = 40;
    localparam int RESET_CYCLES   = 16;
    localparam int SEED           = 65495;
    localparam int CW             = BLOCK_WIDTH;
    localparam int MISALIGN_ADDRS = 32;
    localparam int STORE_COUNT    = 16;
    localparam int TOUCH_COUNT    = 8;

    // Cycle budget per test group.
    localparam int TEST_CYCLES = RESET_CYCLES + 1 + 1 + 4 * MISALIGN_ADDRS + 19
                               + 3 * STORE_COUNT + 12 + 4 + 3 * TOUCH_COUNT + 4;

    logic                   clk;
    logic                   arstn;
    logic [ADDR_WIDTH-1:0]  i_addr;
    logic [REG_WIDTH-1:0]   i_wdata;
    logic [BLOCK_WIDTH-1:0] i_block;
    store_type_e            i_store_type;
    logic                   i_write_en;
    logic                   i_block_write_en;
    logic                   i_valid_update;
    logic                   i_lru_update;
    logic                   i_addr_control;
    logic [REG_WIDTH-1:0]   o_rdata;
    logic [BLOCK_WIDTH-1:0] o_block;
    logic                   o_hit;
    logic                   o_dirty;
    logic [ADDR_WIDTH-1:0]  o_line_addr;
    logic                   o_store_misaligned;

    data_cache #(.SET_COUNT(REF_SETS)) dut_i (
        .clk                (clk),
        .arstn              (arstn),
        .i_addr             (i_addr),
        .i_wdata            (i_wdata),
        .i_block            (i_block),
        .i_store_type       (i_store_type),
        .i_write_en         (i_write_en),
        .i_block_write_en   (i_block_write_en),
        .i_valid_update     (i_valid_update),
        .i_lru_update       (i_lru_update),
        .i_addr_control     (i_addr_control),
        .o_rdata            (o_rdata),
        .o_block            (o_block),
        .o_hit              (o_hit),
        .o_dirty            (o_dirty),
        .o_line_addr        (o_line_addr),
        .o_store_misaligned (o_store_misaligned)
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    initial begin
        #(2 * TEST_CYCLES * CLK_PERIOD);
        $display("Timeout: the test sequence did not finish within %0d cycles", 2 * TEST_CYCLES);
        $display("Some tests failed");
        $fatal(1, "watchdog expired");
    end

    // --------------------
    // Helpers.
    // --------------------
    task automatic check_value(input string name, input logic [CW-1:0] got,
                               input logic [CW-1:0] exp);
        if (got !== exp) begin
            $display("FAIL time=%0t signal=%s got=%0h expected=%0h", $time, name, got, exp);
            $display("Some tests failed");
            $fatal(1, "mismatch on %s", name);
        end
    endtask

    function automatic logic [BLOCK_WIDTH-1:0] rand_block();
        logic [BLOCK_WIDTH-1:0] b;
        for (int i = 0; i < BLOCK_WIDTH / 32; i++) begin
            b[i*32 +: 32] = $urandom;
        end
        return b;
    endfunction

    function automatic logic [ADDR_WIDTH-1:0] make_addr(logic [REF_TAG_W-1:0] tag, int set,
                                                        int off);
        return {tag, REF_INDEX_W'(set), OFFSET_W'(off)};
    endfunction

    function automatic void clear_controls();
        i_write_en       = 1'b0;
        i_block_write_en = 1'b0;
        i_valid_update   = 1'b0;
        i_lru_update     = 1'b0;
    endfunction

    task automatic present(input logic [ADDR_WIDTH-1:0] addr, input logic ctrl);
        @(negedge clk);
        i_addr         = addr;
        i_addr_control = ctrl;
        clear_controls();
        #1;
    endtask

    // Refill, valid set and LRU touch in one cycle.
    task automatic refill_line(input logic [ADDR_WIDTH-1:0] addr,
                               input logic [BLOCK_WIDTH-1:0] blk);
        int s;
        int v;
        s = ref_index(addr);
        v = ref_victim(s);
        @(negedge clk);
        i_addr           = addr;
        i_addr_control   = 1'b1;
        i_block          = blk;
        i_block_write_en = 1'b1;
        i_valid_update   = 1'b1;
        i_lru_update     = 1'b1;
        @(negedge clk);
        clear_controls();
        ref_refill(addr, blk);
        ref_touch(s, v);
    endtask

    task automatic store_data(input logic [ADDR_WIDTH-1:0] addr, input store_type_e st,
                              input logic [REG_WIDTH-1:0] wdata);
        int s;
        int w;
        s = ref_index(addr);
        w = ref_lookup(addr);
        if (w < 0) begin
            $display("Store was issued to an address that is not cached");
            $display("Some tests failed");
            $fatal(1, "bad test sequence");
        end
        @(negedge clk);
        i_addr       = addr;
        i_store_type = st;
        i_wdata      = wdata;
        i_write_en   = 1'b1;
        @(negedge clk);
        clear_controls();
        ref_block[s][w] = ref_merge(ref_block[s][w], addr, st, wdata);
        ref_dirty[s][w] = 1'b1;
    endtask

    task automatic touch_line(input logic [ADDR_WIDTH-1:0] addr);
        int w;
        w = ref_lookup(addr);
        @(negedge clk);
        i_addr       = addr;
        i_lru_update = 1'b1;
        @(negedge clk);
        clear_controls();
        ref_touch(ref_index(addr), w);
    endtask

    task automatic verify_line(input logic [ADDR_WIDTH-1:0] addr);
        int s;
        int w;
        int v;
        s = ref_index(addr);
        w = ref_lookup(addr);
        v = ref_victim(s);
        check_value("o_hit", CW'(o_hit), CW'(w >= 0));
        check_value("o_dirty", CW'(o_dirty), CW'(ref_dirty[s][v]));
        if (w >= 0) begin
            check_value("o_block", o_block, ref_block[s][w]);
            check_value("o_rdata", CW'(o_rdata), CW'(ref_read_word(ref_block[s][w], addr)));
        end
    endtask

    // --------------------
    // Test sequence.
    // --------------------
    initial begin
        logic [ADDR_WIDTH-1:0] a;
        logic [ADDR_WIDTH-1:0] line_a;
        logic [ADDR_WIDTH-1:0] miss;
        logic [ADDR_WIDTH-1:0] lines [WAY_COUNT];
        logic [REF_TAG_W-1:0]  base;
        store_type_e           st;
        int                    set5;
        int                    v;
        int                    k;

        void'($urandom(SEED));
        arstn          = 1'b0;
        i_addr         = '0;
        i_wdata        = '0;
        i_block        = '0;
        i_store_type   = ST_BYTE;
        i_addr_control = 1'b0;
        clear_controls();
        ref_reset();
        repeat (RESET_CYCLES) @(posedge clk);
        @(negedge clk);
        arstn = 1'b1;

        // Reset state with victim way 0 and an unknown tag.
        a = $urandom;
        present(a, 1'b0);
        verify_line(a);
        check_value("o_line_addr", CW'(o_line_addr[OFFSET_W+REF_INDEX_W-1:0]),
                    CW'({REF_INDEX_W'(ref_index(a)), OFFSET_W'(0)}));

        // Misalignment flag for every store size.
        for (int i = 0; i < MISALIGN_ADDRS; i++) begin
            a = $urandom;
            for (int t = 0; t < 4; t++) begin
                @(negedge clk);
                i_addr       = a;
                i_store_type = store_type_e'(2'(t));
                #1;
                check_value("o_store_misaligned", CW'(o_store_misaligned),
                            CW'(ref_misaligned(a, store_type_e'(2'(t)))));
            end
        end

        // Miss, refill, then hit at every word offset.
        line_a = $urandom;
        present(line_a, 1'b1);
        verify_line(line_a);
        check_value("o_line_addr", CW'(o_line_addr),
                    CW'(make_addr(ref_tag_of(line_a), ref_index(line_a), 0)));
        refill_line(line_a, rand_block());
        for (int wo = 0; wo < BLOCK_BYTES / 4; wo++) begin
            a = {line_a[ADDR_WIDTH-1:OFFSET_W], 4'(wo), 2'b00};
            present(a, 1'b1);
            verify_line(a);
        end

        // Stores merged into the hit block.
        for (int i = 0; i < STORE_COUNT; i++) begin
            a  = {line_a[ADDR_WIDTH-1:OFFSET_W], OFFSET_W'($urandom_range(BLOCK_BYTES - 1, 0))};
            st = store_type_e'(2'($urandom_range(3, 0)));
            store_data(a, st, {$urandom, $urandom});
            present(a, 1'b1);
            verify_line(a);
        end

        // --------------------
        // LRU replacement and writeback.
        // --------------------
        set5 = (ref_index(line_a) + 1) % REF_SETS;
        base = REF_TAG_W'($urandom);
        for (int i = 0; i < WAY_COUNT; i++) begin
            lines[i] = make_addr(REF_TAG_W'(base + i), set5, 0);
            present(lines[i], 1'b1);
            verify_line(lines[i]);
            refill_line(lines[i], rand_block());
        end
        // Even lines dirty, odd lines clean.
        for (int i = 0; i < WAY_COUNT; i += 2) begin
            store_data(lines[i] | ADDR_WIDTH'($urandom_range(BLOCK_BYTES - 1, 0)),
                       ST_BYTE, {$urandom, $urandom});
        end
        for (int i = 0; i < TOUCH_COUNT; i++) begin
            k = $urandom_range(WAY_COUNT - 1, 0);
            touch_line(lines[k]);
            present(lines[k], 1'b1);
            verify_line(lines[k]);
        end

        miss = make_addr(REF_TAG_W'(base + WAY_COUNT), set5, 0);
        present(miss, 1'b0);
        verify_line(miss);
        v = ref_victim(set5);
        check_value("o_line_addr", CW'(o_line_addr), CW'(make_addr(ref_tag[set5][v], set5, 0)));

        refill_line(miss, rand_block());
        present(miss, 1'b0);
        verify_line(miss);
        v = ref_victim(set5);
        check_value("o_line_addr", CW'(o_line_addr), CW'(make_addr(ref_tag[set5][v], set5, 0)));

        $display("All tests passed");
        $finish;
    end

endmodule

// ==== tb.f ====
+incdir+include
hw/dcache_pkg.sv
hw/store_unit.sv
hw/tag_array.sv
hw/lru_tracker.sv
hw/data_array.sv
hw/data_cache.sv
sim/tb_data_cache.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the pass line in the output.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f tb.f --top-module tb_data_cache -o tb_data_cache \
    && ./obj_dir/tb_data_cache | tee /dev/stderr | grep -q "All tests passed" \
    && echo "Simulation finished: PASS" \
    || { echo "Simulation finished: FAIL"; exit 1; }
